/* logic/accel_pkg.sv */
/*
 * Accelerator package
 * Shared matrix size, element width and word types for the 4x4 multiplier.
 */
package accel_pkg;

    // matrix dimension
    localparam int MAT_N = 4;

    // element width in bits
    localparam int DW = 8;

    // memory and bus word, one packed row of four elements
    typedef logic [31:0] word_t;

    // signed matrix element
    typedef logic signed [DW-1:0] elem_t;

    // four 8x8 products fit in 18 bits
    typedef logic signed [17:0] acc_t;

    // row-major C index
    typedef logic [3:0] cidx_t;

endpackage

/* logic/apb_regs.sv */
/*
 * APB register slave
 * Decodes control registers and turns memory window accesses into
 * single requester transactions toward the arbiter.
 */
module apb_regs #(
    parameter int MEM_AW = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  logic [11:0]          paddr_i,
    input  accel_pkg::word_t     pwdata_i,
    output logic                 pready_o,
    output accel_pkg::word_t     prdata_o,
    output logic                 pslverr_o,
    output logic                 h_req_o,
    output logic                 h_we_o,
    output logic [MEM_AW-1:0]    h_addr_o,
    output accel_pkg::word_t     h_wdata_o,
    input  logic                 h_gnt_i,
    input  logic                 h_rvalid_i,
    input  accel_pkg::word_t     h_rdata_i,
    output logic                 start_o,
    input  logic                 busy_i,
    input  logic                 done_i,
    output logic [MEM_AW-1:0]    a_base_o,
    output logic [MEM_AW-1:0]    b_base_o,
    output logic [MEM_AW-1:0]    c_base_o
);

    localparam logic [11:0] CTRL_OFF   = 12'h000;
    localparam logic [11:0] STATUS_OFF = 12'h004;
    localparam logic [11:0] A_BASE_OFF = 12'h008;
    localparam logic [11:0] B_BASE_OFF = 12'h00C;
    localparam logic [11:0] C_BASE_OFF = 12'h010;

    logic             acc;
    logic             win;
    logic             win_done;
    logic             reg_hit;
    logic             req_q;
    logic             rd_wait_q;
    logic             done_q;
    accel_pkg::word_t reg_rdata;

    assign acc = psel_i & penable_i;
    // window covers 0x100 to 0x1FC
    assign win = (paddr_i[11:8] == 4'h1);

    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (paddr_i)
            CTRL_OFF:   reg_rdata = '0;
            STATUS_OFF: reg_rdata = accel_pkg::word_t'({done_q, busy_i});
            A_BASE_OFF: reg_rdata = accel_pkg::word_t'(a_base_o);
            B_BASE_OFF: reg_rdata = accel_pkg::word_t'(b_base_o);
            C_BASE_OFF: reg_rdata = accel_pkg::word_t'(c_base_o);
            default:    reg_hit = 1'b0;
        endcase
    end

    // writes finish on grant, reads on the returning rvalid
    assign win_done  = pwrite_i ? (req_q & h_gnt_i) : (rd_wait_q & h_rvalid_i);
    assign pready_o  = acc & (win ? win_done : 1'b1);
    assign pslverr_o = acc & ~win & ~reg_hit;
    assign prdata_o  = (pready_o & ~pwrite_i) ? (win ? h_rdata_i : reg_rdata) : '0;

    assign h_req_o   = req_q;
    assign h_we_o    = pwrite_i;
    assign h_addr_o  = paddr_i[MEM_AW+1:2];
    assign h_wdata_o = pwdata_i;

    assign start_o = acc & pwrite_i & (paddr_i == CTRL_OFF) & pwdata_i[0] & ~busy_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            rd_wait_q <= 1'b0;
            done_q    <= 1'b0;
            a_base_o  <= '0;
            b_base_o  <= '0;
            c_base_o  <= '0;
        end else begin
            // one request per window access
            if (h_gnt_i) begin
                req_q     <= 1'b0;
                rd_wait_q <= ~h_we_o;
            end else if (acc & win & ~req_q & ~rd_wait_q) begin
                req_q <= 1'b1;
            end
            if (h_rvalid_i) begin
                rd_wait_q <= 1'b0;
            end
            if (acc & pwrite_i) begin
                case (paddr_i)
                    A_BASE_OFF: a_base_o <= pwdata_i[MEM_AW-1:0];
                    B_BASE_OFF: b_base_o <= pwdata_i[MEM_AW-1:0];
                    C_BASE_OFF: c_base_o <= pwdata_i[MEM_AW-1:0];
                    default: ;
                endcase
            end
            // sticky done, cleared by a new start
            if (start_o) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
        end
    end

endmodule

/* logic/mem_arbiter.sv */
/*
 * Memory arbiter
 * Round-robin access for the host and DMA requesters to one memory port.
 */
module mem_arbiter #(
    parameter int MEM_AW = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 h_req_i,
    input  logic                 h_we_i,
    input  logic [MEM_AW-1:0]    h_addr_i,
    input  accel_pkg::word_t     h_wdata_i,
    output logic                 h_gnt_o,
    output logic                 h_rvalid_o,
    output accel_pkg::word_t     h_rdata_o,
    input  logic                 d_req_i,
    input  logic                 d_we_i,
    input  logic [MEM_AW-1:0]    d_addr_i,
    input  accel_pkg::word_t     d_wdata_i,
    output logic                 d_gnt_o,
    output logic                 d_rvalid_o,
    output accel_pkg::word_t     d_rdata_o,
    output logic                 m_en_o,
    output logic                 m_we_o,
    output logic [MEM_AW-1:0]    m_addr_o,
    output accel_pkg::word_t     m_wdata_o,
    input  accel_pkg::word_t     m_rdata_i
);

    // 1 when the DMA side won the last grant
    logic last_d_q;
    logic rd_h_q;
    logic rd_d_q;

    assign h_gnt_o = h_req_i & (~d_req_i | last_d_q);
    assign d_gnt_o = d_req_i & (~h_req_i | ~last_d_q);

    assign m_en_o    = h_gnt_o | d_gnt_o;
    assign m_we_o    = d_gnt_o ? d_we_i    : h_we_i;
    assign m_addr_o  = d_gnt_o ? d_addr_i  : h_addr_i;
    assign m_wdata_o = d_gnt_o ? d_wdata_i : h_wdata_i;

    // read data goes only to the owner of the read in flight
    assign h_rvalid_o = rd_h_q;
    assign d_rvalid_o = rd_d_q;
    assign h_rdata_o  = rd_h_q ? m_rdata_i : '0;
    assign d_rdata_o  = rd_d_q ? m_rdata_i : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_d_q <= 1'b0;
            rd_h_q   <= 1'b0;
            rd_d_q   <= 1'b0;
        end else begin
            if (d_gnt_o) begin
                last_d_q <= 1'b1;
            end else if (h_gnt_o) begin
                last_d_q <= 1'b0;
            end
            rd_h_q <= h_gnt_o & ~h_we_i;
            rd_d_q <= d_gnt_o & ~d_we_i;
        end
    end

endmodule

/* logic/data_sram.sv */
/*
 * Data memory
 * Single-port word array, read data valid one cycle after the access.
 */
module data_sram #(
    parameter int MEM_AW = 6
) (
    input  logic                 clk,
    input  logic                 en_i,
    input  logic                 we_i,
    input  logic [MEM_AW-1:0]    addr_i,
    input  accel_pkg::word_t     wdata_i,
    output accel_pkg::word_t     rdata_o
);

    accel_pkg::word_t mem [2**MEM_AW];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

/* logic/dma_engine.sv */
/*
 * DMA job sequencer
 * Fetches the A and B rows from memory, starts the multiply and
 * writes the sixteen C results back.
 */
module dma_engine #(
    parameter int MEM_AW = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic [MEM_AW-1:0]    a_base_i,
    input  logic [MEM_AW-1:0]    b_base_i,
    input  logic [MEM_AW-1:0]    c_base_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic                 d_req_o,
    output logic                 d_we_o,
    output logic [MEM_AW-1:0]    d_addr_o,
    output accel_pkg::word_t     d_wdata_o,
    input  logic                 d_gnt_i,
    input  logic                 d_rvalid_i,
    input  accel_pkg::word_t     d_rdata_i,
    output logic                 a_we_o,
    output logic                 b_we_o,
    output logic [$clog2(accel_pkg::MAT_N)-1:0] row_o,
    output accel_pkg::word_t     row_data_o,
    output logic                 mm_start_o,
    input  logic                 mm_done_i,
    output accel_pkg::cidx_t     c_idx_o,
    input  accel_pkg::acc_t      c_data_i
);

    localparam int N_ROWS = 2 * accel_pkg::MAT_N;
    localparam int N_C    = accel_pkg::MAT_N * accel_pkg::MAT_N;
    localparam int CW     = $clog2(N_ROWS + 1);
    localparam int RW     = $clog2(accel_pkg::MAT_N);
    localparam int EXT_W  = $bits(accel_pkg::word_t) - $bits(accel_pkg::acc_t);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_COMPUTE,
        S_STORE,
        S_FINISH
    } state_t;

    state_t           state_q;
    logic [CW-1:0]    iss_cnt_q;
    logic [CW-1:0]    ret_cnt_q;
    accel_pkg::cidx_t c_cnt_q;
    logic             fetch_a;

    assign busy_o = (state_q != S_IDLE);
    assign done_o = (state_q == S_FINISH);

    // first MAT_N reads go to A, the rest to B
    assign fetch_a = (iss_cnt_q < CW'(accel_pkg::MAT_N));

    always_comb begin
        d_req_o   = 1'b0;
        d_we_o    = 1'b0;
        d_addr_o  = '0;
        d_wdata_o = '0;
        if (state_q == S_FETCH && iss_cnt_q < CW'(N_ROWS)) begin
            d_req_o  = 1'b1;
            d_addr_o = fetch_a ? a_base_i + MEM_AW'(iss_cnt_q)
                               : b_base_i + MEM_AW'(iss_cnt_q - CW'(accel_pkg::MAT_N));
        end else if (state_q == S_STORE) begin
            d_req_o   = 1'b1;
            d_we_o    = 1'b1;
            d_addr_o  = c_base_i + MEM_AW'(c_cnt_q);
            d_wdata_o = {{EXT_W{c_data_i[$bits(accel_pkg::acc_t)-1]}}, c_data_i};
        end
    end

    // returning words are steered by arrival order
    assign a_we_o     = (state_q == S_FETCH) & d_rvalid_i & (ret_cnt_q < CW'(accel_pkg::MAT_N));
    assign b_we_o     = (state_q == S_FETCH) & d_rvalid_i & (ret_cnt_q >= CW'(accel_pkg::MAT_N));
    assign row_o      = ret_cnt_q[RW-1:0];
    assign row_data_o = d_rdata_i;
    assign c_idx_o    = c_cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            iss_cnt_q  <= '0;
            ret_cnt_q  <= '0;
            c_cnt_q    <= '0;
            mm_start_o <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        iss_cnt_q <= '0;
                        ret_cnt_q <= '0;
                        c_cnt_q   <= '0;
                        state_q   <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (d_gnt_i) begin
                        iss_cnt_q <= iss_cnt_q + 1'b1;
                    end
                    if (d_rvalid_i) begin
                        ret_cnt_q <= ret_cnt_q + 1'b1;
                        if (ret_cnt_q == CW'(N_ROWS - 1)) begin
                            mm_start_o <= 1'b1;
                            state_q    <= S_COMPUTE;
                        end
                    end
                end
                S_COMPUTE: begin
                    if (mm_done_i) begin
                        state_q <= S_STORE;
                    end
                end
                S_STORE: begin
                    if (d_gnt_i) begin
                        c_cnt_q <= c_cnt_q + 1'b1;
                        if (c_cnt_q == accel_pkg::cidx_t'(N_C - 1)) begin
                            state_q <= S_FINISH;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

/* logic/mm_engine.sv */
/*
 * Multiply engine
 * Operand registers for A and B and a 4x4 accumulator array that
 * takes one k step per cycle.
 */
module mm_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 a_we_i,
    input  logic                 b_we_i,
    input  logic [$clog2(accel_pkg::MAT_N)-1:0] row_i,
    input  accel_pkg::word_t     row_data_i,
    input  logic                 start_i,
    output logic                 done_o,
    input  accel_pkg::cidx_t     c_idx_i,
    output accel_pkg::acc_t      c_data_o
);

    localparam int N  = accel_pkg::MAT_N;
    localparam int KW = $clog2(N);

    accel_pkg::elem_t a_q   [N][N];
    accel_pkg::elem_t b_q   [N][N];
    accel_pkg::acc_t  acc_q [N][N];

    logic          run_q;
    logic [KW-1:0] k_q;

    // element j sits in byte j of the row word
    always_ff @(posedge clk) begin
        for (int j = 0; j < N; j++) begin
            if (a_we_i) begin
                a_q[row_i][j] <= row_data_i[j*accel_pkg::DW +: accel_pkg::DW];
            end
            if (b_we_i) begin
                b_q[row_i][j] <= row_data_i[j*accel_pkg::DW +: accel_pkg::DW];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (start_i) begin
                    acc_q[i][j] <= '0;
                end else if (run_q) begin
                    acc_q[i][j] <= acc_q[i][j] + a_q[i][k_q] * b_q[k_q][j];
                end
            end
        end
    end

    // k sweep, done on the last step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            k_q    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                run_q <= 1'b1;
                k_q   <= '0;
            end else if (run_q) begin
                k_q <= k_q + 1'b1;
                if (k_q == KW'(N - 1)) begin
                    run_q  <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    assign c_data_o = acc_q[c_idx_i / N][c_idx_i % N];

endmodule

/* logic/accel_top.sv */
/*
 * Matrix multiply accelerator top
 * APB slave and DMA engine share one data memory through the arbiter.
 */
module accel_top #(
    parameter int MEM_AW = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  logic [11:0]          paddr_i,
    input  accel_pkg::word_t     pwdata_i,
    output logic                 pready_o,
    output accel_pkg::word_t     prdata_o,
    output logic                 pslverr_o,
    output logic                 done_irq_o
);

    // host requester
    logic             h_req, h_we, h_gnt, h_rvalid;
    logic [MEM_AW-1:0] h_addr;
    accel_pkg::word_t h_wdata, h_rdata;

    // DMA requester
    logic             d_req, d_we, d_gnt, d_rvalid;
    logic [MEM_AW-1:0] d_addr;
    accel_pkg::word_t d_wdata, d_rdata;

    // memory port
    logic             m_en, m_we;
    logic [MEM_AW-1:0] m_addr;
    accel_pkg::word_t m_wdata, m_rdata;

    // control and operand path
    logic              start, busy;
    logic [MEM_AW-1:0] a_base, b_base, c_base;
    logic              a_we, b_we, mm_start, mm_done;
    logic [$clog2(accel_pkg::MAT_N)-1:0] row;
    accel_pkg::word_t  row_data;
    accel_pkg::cidx_t  c_idx;
    accel_pkg::acc_t   c_data;

    apb_regs #(.MEM_AW(MEM_AW)) u_apb_regs (
        .clk, .rst_n,
        .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .pready_o, .prdata_o, .pslverr_o,
        .h_req_o(h_req), .h_we_o(h_we), .h_addr_o(h_addr), .h_wdata_o(h_wdata),
        .h_gnt_i(h_gnt), .h_rvalid_i(h_rvalid), .h_rdata_i(h_rdata),
        .start_o(start), .busy_i(busy), .done_i(done_irq_o),
        .a_base_o(a_base), .b_base_o(b_base), .c_base_o(c_base)
    );

    mem_arbiter #(.MEM_AW(MEM_AW)) u_mem_arbiter (
        .clk, .rst_n,
        .h_req_i(h_req), .h_we_i(h_we), .h_addr_i(h_addr), .h_wdata_i(h_wdata),
        .h_gnt_o(h_gnt), .h_rvalid_o(h_rvalid), .h_rdata_o(h_rdata),
        .d_req_i(d_req), .d_we_i(d_we), .d_addr_i(d_addr), .d_wdata_i(d_wdata),
        .d_gnt_o(d_gnt), .d_rvalid_o(d_rvalid), .d_rdata_o(d_rdata),
        .m_en_o(m_en), .m_we_o(m_we), .m_addr_o(m_addr), .m_wdata_o(m_wdata),
        .m_rdata_i(m_rdata)
    );

    data_sram #(.MEM_AW(MEM_AW)) u_data_sram (
        .clk,
        .en_i(m_en), .we_i(m_we), .addr_i(m_addr), .wdata_i(m_wdata),
        .rdata_o(m_rdata)
    );

    dma_engine #(.MEM_AW(MEM_AW)) u_dma_engine (
        .clk, .rst_n,
        .start_i(start), .a_base_i(a_base), .b_base_i(b_base), .c_base_i(c_base),
        .busy_o(busy), .done_o(done_irq_o),
        .d_req_o(d_req), .d_we_o(d_we), .d_addr_o(d_addr), .d_wdata_o(d_wdata),
        .d_gnt_i(d_gnt), .d_rvalid_i(d_rvalid), .d_rdata_i(d_rdata),
        .a_we_o(a_we), .b_we_o(b_we), .row_o(row), .row_data_o(row_data),
        .mm_start_o(mm_start), .mm_done_i(mm_done),
        .c_idx_o(c_idx), .c_data_i(c_data)
    );

    mm_engine u_mm_engine (
        .clk, .rst_n,
        .a_we_i(a_we), .b_we_i(b_we), .row_i(row), .row_data_i(row_data),
        .start_i(mm_start), .done_o(mm_done),
        .c_idx_i(c_idx), .c_data_o(c_data)
    );

endmodule

/* bench/clk_gen.sv */
/*
 * Testbench clock and reset
 * Free-running clock and an active-low reset held for a set number of cycles.
 */
module clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a rising edge, the DUT samples it on the next one
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* bench/accel_asserts.sv */
/*
 * Accelerator protocol checks
 * Watches arbiter grants, read returns, APB read data and the done pulse.
 */
module accel_asserts (
    input logic             clk,
    input logic             rst_n,
    input logic             h_req_i,
    input logic             h_we_i,
    input logic             h_gnt_i,
    input logic             h_rvalid_i,
    input logic             d_req_i,
    input logic             d_we_i,
    input logic             d_gnt_i,
    input logic             d_rvalid_i,
    input logic             pready_i,
    input accel_pkg::word_t prdata_i,
    input logic             done_irq_i
);

    // failures seen so far, polled by the testbench
    int fail_cnt = 0;

    no_double_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(h_gnt_i && d_gnt_i))
        else begin
            $error("host and DMA granted in the same cycle");
            fail_cnt++;
        end

    h_rvalid_timing: assert property (@(posedge clk) disable iff (!rst_n)
        h_rvalid_i == $past(h_gnt_i && !h_we_i))
        else begin
            $error("host rvalid not one cycle after its read grant");
            fail_cnt++;
        end

    d_rvalid_timing: assert property (@(posedge clk) disable iff (!rst_n)
        d_rvalid_i == $past(d_gnt_i && !d_we_i))
        else begin
            $error("DMA rvalid not one cycle after its read grant");
            fail_cnt++;
        end

    // round robin bounds the wait of a held request
    h_grant_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (h_req_i && !h_gnt_i) |-> ##[1:2] h_gnt_i)
        else begin
            $error("host request waited more than two cycles");
            fail_cnt++;
        end

    d_grant_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (d_req_i && !d_gnt_i) |-> ##[1:2] d_gnt_i)
        else begin
            $error("DMA request waited more than two cycles");
            fail_cnt++;
        end

    prdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (!pready_i ##1 !pready_i) |-> $stable(prdata_i))
        else begin
            $error("prdata changed while pready was low");
            fail_cnt++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_irq_i |=> !done_irq_i)
        else begin
            $error("done_irq_o lasted more than one cycle");
            fail_cnt++;
        end

endmodule

bind accel_top accel_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .h_req_i    (h_req),
    .h_we_i     (h_we),
    .h_gnt_i    (h_gnt),
    .h_rvalid_i (h_rvalid),
    .d_req_i    (d_req),
    .d_we_i     (d_we),
    .d_gnt_i    (d_gnt),
    .d_rvalid_i (d_rvalid),
    .pready_i   (pready_o),
    .prdata_i   (prdata_o),
    .done_irq_i (done_irq_o)
);

/* bench/accel_tb.sv */
/*
 * Accelerator testbench
 * Drives APB, loads random matrices, checks C against a reference product
 * and runs host memory traffic during a job.
 */
module accel_tb;

    localparam logic [11:0] CTRL_ADDR     = 12'h000;
    localparam logic [11:0] STATUS_ADDR   = 12'h004;
    localparam logic [11:0] A_BASE_ADDR   = 12'h008;
    localparam logic [11:0] B_BASE_ADDR   = 12'h00C;
    localparam logic [11:0] C_BASE_ADDR   = 12'h010;
    localparam logic [11:0] WIN_ADDR      = 12'h100;
    localparam logic [11:0] UNMAPPED_ADDR = 12'h020;
    localparam int          N             = 4;
    localparam int          C_WORD        = 16;
    // several times the length of all tests
    localparam int          TIMEOUT_CYCLES = 6000;

    logic                 clk;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [11:0]          paddr;
    accel_pkg::word_t     pwdata;
    logic                 pready;
    accel_pkg::word_t     prdata;
    logic                 pslverr;
    logic                 done_irq;

    logic [15:0] lfsr_q;
    int          cycle_cnt = 0;
    int          done_cnt = 0;
    int          a_m   [N][N];
    int          b_m   [N][N];
    int          c_ref [N][N];

    clk_gen #(.PERIOD(100), .RST_CYCLES(16)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    accel_top #(.MEM_AW(6)) DUT (
        .clk, .rst_n,
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
        .done_irq_o(done_irq)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input accel_pkg::word_t exp,
                              input accel_pkg::word_t act);
        assert (act === exp)
            else abort_run($sformatf("mismatch at %0t: %s expected 0x%08h got 0x%08h",
                                     $time, name, exp, act));
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output accel_pkg::word_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [11:0] win_addr(input int word);
        return WIN_ADDR + 12'(4 * word);
    endfunction

    // setup on one edge, access on the next, sample at the falling edge
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input accel_pkg::word_t wdata,
                              output accel_pkg::word_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(negedge clk);
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input logic [11:0] addr, input accel_pkg::word_t data);
        accel_pkg::word_t rd;
        logic             err;
        apb_access(1'b1, addr, data, rd, err);
        check_word($sformatf("pslverr (write 0x%03h)", addr), '0, err);
    endtask

    task automatic expect_read(input string name, input logic [11:0] addr,
                               input accel_pkg::word_t exp);
        accel_pkg::word_t rd;
        logic             err;
        apb_access(1'b0, addr, '0, rd, err);
        check_word($sformatf("pslverr (read 0x%03h)", addr), '0, err);
        check_word(name, exp, rd);
    endtask

    // random rows into the window and into the model arrays
    task automatic load_matrices(input int a_base, input int b_base);
        accel_pkg::word_t rnd;
        accel_pkg::word_t row_a;
        accel_pkg::word_t row_b;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                rand_bits(8, rnd);
                a_m[i][j]      = $signed(rnd[7:0]);
                row_a[j*8 +: 8] = rnd[7:0];
                rand_bits(8, rnd);
                b_m[i][j]      = $signed(rnd[7:0]);
                row_b[j*8 +: 8] = rnd[7:0];
            end
            reg_write(win_addr(a_base + i), row_a);
            reg_write(win_addr(b_base + i), row_b);
        end
        reg_write(A_BASE_ADDR, a_base);
        reg_write(B_BASE_ADDR, b_base);
    endtask

    function automatic void compute_ref();
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                c_ref[i][j] = 0;
                for (int k = 0; k < N; k++) begin
                    c_ref[i][j] += a_m[i][k] * b_m[k][j];
                end
            end
        end
    endfunction

    task automatic check_c(input int c_base);
        for (int idx = 0; idx < N * N; idx++) begin
            expect_read($sformatf("C[%0d][%0d]", idx / N, idx % N), win_addr(c_base + idx),
                        accel_pkg::word_t'(c_ref[idx / N][idx % N]));
        end
    endtask

    // unrelated words 40 to 47 while the DMA engine is active
    // each write is read back at once so host reads meet DMA reads
    task automatic host_traffic();
        accel_pkg::word_t wv;
        for (int i = 0; i < 8; i++) begin
            rand_bits(32, wv);
            reg_write(win_addr(40 + i), wv);
            expect_read($sformatf("mem[%0d]", 40 + i), win_addr(40 + i), wv);
        end
    endtask

    task automatic wait_done(input int target);
        while (done_cnt < target) begin
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && done_irq) begin
            done_cnt++;
        end
        if (rst_n && !psel) begin
            assert (!pready) else abort_run("pready is high outside an APB access");
        end
        if (DUT.u_asserts.fail_cnt != 0) begin
            abort_run("a bound protocol assertion failed");
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        accel_pkg::word_t rd;
        logic             err;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        lfsr_q  = 16'd9;
        do begin
            @(posedge clk);
        end while (!rst_n);

        // reset state
        expect_read("STATUS", STATUS_ADDR, 32'h0);
        check_word("done pulses", 0, done_cnt);

        // base registers, window and unmapped addresses
        reg_write(A_BASE_ADDR, 32'd21);
        reg_write(B_BASE_ADDR, 32'd42);
        reg_write(C_BASE_ADDR, 32'd63);
        expect_read("A_BASE", A_BASE_ADDR, 32'd21);
        expect_read("B_BASE", B_BASE_ADDR, 32'd42);
        expect_read("C_BASE", C_BASE_ADDR, 32'd63);
        reg_write(win_addr(50), 32'hA5C3_0F96);
        expect_read("mem[50]", win_addr(50), 32'hA5C3_0F96);
        apb_access(1'b0, UNMAPPED_ADDR, '0, rd, err);
        check_word("pslverr (read unmapped)", 1, err);
        apb_access(1'b1, 12'h200, 32'h1, rd, err);
        check_word("pslverr (write unmapped)", 1, err);

        // first job with host traffic alongside
        load_matrices(0, 4);
        compute_ref();
        reg_write(C_BASE_ADDR, C_WORD);
        reg_write(CTRL_ADDR, 32'h1);
        host_traffic();
        wait_done(1);
        check_c(C_WORD);
        expect_read("STATUS", STATUS_ADDR, 32'h2);

        // second job with a repeated start while busy
        load_matrices(8, 12);
        compute_ref();
        reg_write(CTRL_ADDR, 32'h1);
        reg_write(CTRL_ADDR, 32'h1);
        expect_read("STATUS", STATUS_ADDR, 32'h1);
        wait_done(2);
        check_c(C_WORD);
        expect_read("STATUS", STATUS_ADDR, 32'h2);
        check_word("done pulses", 2, done_cnt);

        if (DUT.u_asserts.fail_cnt != 0) begin
            abort_run("a bound protocol assertion failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* sim.f */
logic/accel_pkg.sv
logic/apb_regs.sv
logic/mem_arbiter.sv
logic/data_sram.sv
logic/dma_engine.sv
logic/mm_engine.sv
logic/accel_top.sv
bench/clk_gen.sv
bench/accel_asserts.sv
bench/accel_tb.sv

/* Bender.yml */
package:
  name: matmul_accel

sources:
  - logic/accel_pkg.sv
  - logic/apb_regs.sv
  - logic/mem_arbiter.sv
  - logic/data_sram.sv
  - logic/dma_engine.sv
  - logic/mm_engine.sv
  - logic/accel_top.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/accel_asserts.sv
      - bench/accel_tb.sv
